/* src.f */
+incdir+src
src/lsu_pkg.sv
src/pipe_stage.sv
src/beat_issue.sv
src/load_assemble.sv
src/vector_lsu.sv
testbench/bank_model.sv
testbench/tb_vector_lsu.sv

/* Bender.yml */
package:
  name: vector_lsu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/pipe_stage.sv
      - src/beat_issue.sv
      - src/load_assemble.sv
      - src/vector_lsu.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/bank_model.sv
      - testbench/tb_vector_lsu.sv

/* testbench/tb_vector_lsu.sv */
// vector lsu testbench

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module tb_vector_lsu
    import lsu_pkg::*;
();

    // 3 stores, 3 loads, 10 reserved lmul, 40 mixed
    localparam int num_requests = 56;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = 200 * num_requests + reset_cycles;

    logic                 clk;
    logic                 nrst;
    logic                 req_valid;
    logic                 req_ready;
    lsu_req_t             req_data;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    bank_req_t            mem_req;
    logic                 mem_rsp_valid;
    logic [`LSU_VLEN-1:0] mem_rsp_data;
    logic                 res_valid;
    logic                 res_ready;
    load_result_t         res_data;
    logic                 st_done;
    logic                 stall_en;

    logic [`LSU_BANK_WIDTH-1:0] shadow [0:(1<<`LSU_ADDR_BITS)-1];
    load_result_t               exp_q [$];
    logic [`LSU_ADDR_BITS-1:0]  bases [0:2];
    load_result_t               expected;
    load_result_t               held_data;
    logic                       hold_pending = 1'b0;
    integer                     seed;
    integer                     ready_seed;
    string                      test_name = "reset";
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle = 0;
    int n_loads = 0;
    int n_stores = 0;
    int res_cnt = 0;
    int st_cnt = 0;

    vector_lsu dut0 (
        .clk           (clk),
        .nrst          (nrst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_data      (req_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_data      (res_data),
        .st_done       (st_done)
    );

    bank_model mem0 (
        .clk           (clk),
        .nrst          (nrst),
        .stall_en      (stall_en),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        #1;
        res_ready = !stall_en || (($random(ready_seed) & 3) != 0);
    end

    // results, held-result stability and store completions at mid-cycle
    always @(negedge clk) begin
        if (nrst) begin
            if (hold_pending) begin
                assert (res_valid && res_data === held_data) else begin
                    errors++;
                    $display("ERR %s: held result expected %h, got %h", test_name,
                             held_data, res_data);
                end
            end
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: load result arrived with no load outstanding", test_name);
                end else begin
                    expected = exp_q.pop_front();
                    assert (res_data === expected) else begin
                        errors++;
                        $display("ERR %s: load result expected %h, got %h", test_name,
                                 expected, res_data);
                    end
                end
                res_cnt++;
            end
            if (st_done) begin
                st_cnt++;
            end
            hold_pending = res_valid && !res_ready;
            held_data    = res_data;
        end
    end

    function automatic int group_words(input logic [2:0] lmul);
        case (lmul)
            3'd1:    return 8;
            3'd2:    return 16;
            default: return 4;
        endcase
    endfunction

    task automatic send_request(input lsu_op_e op, input logic [2:0] lmul,
                                input logic [`LSU_ADDR_BITS-1:0] base);
        lsu_req_t     r;
        load_result_t exp;
        logic         taken;
        int           n;
        n      = group_words(lmul);
        r.op   = op;
        r.lmul = lmul;
        r.base = base;
        for (int w = 0; w < 16; w++) begin
            r.data[32*w +: 32] = $random(seed);
        end
        if (op == LSU_STORE) begin
            for (int i = 0; i < n; i++) begin
                shadow[base + `LSU_ADDR_BITS'(i)] = r.data[32*i +: 32];
            end
            n_stores++;
        end else begin
            exp = '0;
            for (int i = 0; i < n; i++) begin
                exp[32*i +: 32] = shadow[base + `LSU_ADDR_BITS'(i)];
            end
            exp_q.push_back(exp);
            n_loads++;
        end
        req_data  = r;
        req_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || st_cnt < n_stores) begin
            @(negedge clk);
        end
        // room for any stray pulse or result to show up
        repeat (8) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic check_memory();
        for (int a = 0; a < (1 << `LSU_ADDR_BITS); a++) begin
            assert (mem0.words[a] === shadow[a]) else begin
                errors++;
                $display("ERR %s: word %h expected %h, got %h", test_name, a[11:0],
                         shadow[a], mem0.words[a]);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        assert (st_cnt == n_stores) else begin
            errors++;
            $display("ERR %s: store completions expected %0d, got %0d", test_name,
                     n_stores, st_cnt);
        end
        assert (res_cnt == n_loads) else begin
            errors++;
            $display("ERR %s: load results expected %0d, got %0d", test_name,
                     n_loads, res_cnt);
        end
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    initial begin
        logic [`LSU_ADDR_BITS-1:0] base;
        seed       = 32'hbbfb_1974;
        ready_seed = 32'hbbfb_1974;
        nrst       = 1'b0;
        req_valid  = 1'b0;
        req_data   = '0;
        res_ready  = 1'b1;
        stall_en   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        for (int a = 0; a < (1 << `LSU_ADDR_BITS); a++) begin
            shadow[a] = mem0.words[a];
        end
        #1;
        nrst = 1'b1;

        start_test("idle");
        repeat (20) begin
            @(negedge clk);
            assert (!mem_req_valid && !res_valid && !st_done) else begin
                errors++;
                $display("idle: unit became active with no request");
            end
        end
        @(posedge clk);
        #1;
        end_test();

        start_test("store_lmul");
        for (int l = 0; l < 3; l++) begin
            bases[l] = `LSU_ADDR_BITS'($random(seed));
            send_request(LSU_STORE, 3'(l), bases[l]);
        end
        drain();
        check_memory();
        end_test();

        start_test("load_lmul");
        for (int l = 0; l < 3; l++) begin
            send_request(LSU_LOAD, 3'(l), bases[l]);
        end
        drain();
        end_test();

        // reserved encodings act on a single register
        start_test("lmul_reserved");
        for (int l = 3; l < 8; l++) begin
            base = `LSU_ADDR_BITS'($random(seed));
            send_request(LSU_STORE, 3'(l), base);
            send_request(LSU_LOAD, 3'(l), base);
        end
        drain();
        check_memory();
        end_test();

        // narrow address window so loads hit recent stores
        start_test("random_mix");
        stall_en = 1'b1;
        repeat (40) begin
            base = `LSU_ADDR_BITS'($random(seed) & 8'hff);
            send_request((($random(seed) & 1) != 0) ? LSU_STORE : LSU_LOAD,
                         3'($random(seed)), base);
        end
        drain();
        stall_en = 1'b0;
        check_memory();
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/bank_model.sv */
// bank memory model

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module bank_model
    import lsu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            nrst,
    input  wire logic            stall_en,

    input  wire logic            mem_req_valid,
    output logic                 mem_req_ready,
    input  wire bank_req_t       mem_req,

    output logic                 mem_rsp_valid,
    output logic [`LSU_VLEN-1:0] mem_rsp_data
);

    logic [`LSU_BANK_WIDTH-1:0] words [0:(1<<`LSU_ADDR_BITS)-1];

    // pending read beats with the cycle each one may go out
    logic [`LSU_VLEN-1:0] rsp_q [$];
    int                   due_q [$];
    integer               seed;
    int                   cycle;
    int                   last_due;
    int                   due;
    logic                 take;
    bank_req_t            beat;
    logic [`LSU_VLEN-1:0] rd;

    initial begin
        seed          = 32'hbbfb_1974;
        cycle         = 0;
        last_due      = 0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        // fill pattern built from the whole word address
        for (int a = 0; a < (1 << `LSU_ADDR_BITS); a++) begin
            words[a] = {4'ha, 12'(a), 4'h5, ~12'(a)};
        end
        forever begin
            @(negedge clk);
            take = nrst && mem_req_valid && mem_req_ready;
            beat = mem_req;
            @(posedge clk);
            cycle++;
            if (take) begin
                for (int j = 0; j < `LSU_BANKS; j++) begin
                    if (beat.write) begin
                        words[beat.addr[j]] = beat.wdata[j];
                    end else begin
                        rd[j*`LSU_BANK_WIDTH +: `LSU_BANK_WIDTH] = words[beat.addr[j]];
                    end
                end
                if (!beat.write) begin
                    // 1 to 4 cycles later without overtaking an earlier beat
                    due = cycle + 1 + ($random(seed) & 3);
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    rsp_q.push_back(rd);
                    due_q.push_back(due);
                end
            end
            #1;
            mem_req_ready = !stall_en || (($random(seed) & 3) != 0);
            if (rsp_q.size() != 0 && due_q[0] <= cycle) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = rsp_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                mem_rsp_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/vector_lsu.sv */
// vector load/store unit

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module vector_lsu
    import lsu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 nrst,

    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire lsu_req_t             req_data,

    output logic                      mem_req_valid,
    input  wire logic                 mem_req_ready,
    output bank_req_t                 mem_req,

    input  wire logic                 mem_rsp_valid,
    input  wire logic [`LSU_VLEN-1:0] mem_rsp_data,

    output logic                      res_valid,
    input  wire logic                 res_ready,
    output load_result_t              res_data,

    output logic                      st_done
);

    lsu_req_t     issue_req;
    logic         issue_valid;
    logic         issue_ready;
    load_tag_t    tag;
    logic         tag_valid;
    logic         tag_ready;
    load_result_t asm_res;
    logic         asm_valid;
    logic         asm_ready;

    pipe_stage #(.payload_t(lsu_req_t)) req_stage0 (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req_data),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_req)
    );

    beat_issue beat_issue0 (
        .clk           (clk),
        .nrst          (nrst),
        .req_valid     (issue_valid),
        .req_ready     (issue_ready),
        .req           (issue_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .tag_valid     (tag_valid),
        .tag_ready     (tag_ready),
        .tag           (tag),
        .st_done       (st_done)
    );

    load_assemble load_assemble0 (
        .clk           (clk),
        .nrst          (nrst),
        .tag_valid     (tag_valid),
        .tag_ready     (tag_ready),
        .tag           (tag),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .res_valid     (asm_valid),
        .res_ready     (asm_ready),
        .res           (asm_res)
    );

    pipe_stage #(.payload_t(load_result_t)) res_stage0 (
        .clk       (clk),
        .nrst      (nrst),
        .in_valid  (asm_valid),
        .in_ready  (asm_ready),
        .in_data   (asm_res),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res_data)
    );

endmodule

`default_nettype wire

/* src/load_assemble.sv */
// vector lsu load assembly

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module load_assemble
    import lsu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 nrst,

    // tag from beat issue
    input  wire logic                 tag_valid,
    output logic                      tag_ready,
    input  wire load_tag_t            tag,

    // response beats, four bank words each
    input  wire logic                 mem_rsp_valid,
    input  wire logic [`LSU_VLEN-1:0] mem_rsp_data,

    // finished group
    output logic                      res_valid,
    input  wire logic                 res_ready,
    output load_result_t              res
);

    logic         tag_full;
    logic [2:0]   cnt;
    logic [2:0]   beats_q;
    load_result_t group_q;

    logic tag_hs;
    logic done;
    logic rsp_take;

    // one load in flight at a time
    assign tag_ready = !tag_full;
    assign tag_hs    = tag_valid && tag_ready;

    assign done     = tag_full && (cnt == beats_q);
    assign rsp_take = mem_rsp_valid && tag_full && !done;

    assign res_valid = done;
    assign res       = group_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            tag_full <= 1'b0;
            cnt      <= 3'd0;
        end else if (tag_hs) begin
            tag_full <= 1'b1;
            cnt      <= 3'd0;
        end else if (res_valid && res_ready) begin
            // slot frees only once the group has moved downstream
            tag_full <= 1'b0;
        end else if (rsp_take) begin
            cnt <= cnt + 3'd1;
        end
    end

    // upper registers stay zero for short groups
    always_ff @(posedge clk) begin
        if (tag_hs) begin
            beats_q <= tag.beats;
            group_q <= '0;
        end else if (rsp_take) begin
            group_q[cnt*`LSU_VLEN +: `LSU_VLEN] <= mem_rsp_data;
        end
    end

endmodule

`default_nettype wire

/* src/beat_issue.sv */
// vector lsu beat issue

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module beat_issue
    import lsu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      nrst,

    // request from the request stage
    input  wire logic      req_valid,
    output logic           req_ready,
    input  wire lsu_req_t  req,

    // beat to the memory banks
    output logic           mem_req_valid,
    input  wire logic      mem_req_ready,
    output bank_req_t      mem_req,

    // load tag to assembly
    output logic           tag_valid,
    input  wire logic      tag_ready,
    output load_tag_t      tag,

    output logic           st_done
);

    // control state
    logic       busy;
    logic [2:0] beat_cnt;

    // current request, advanced one beat at a time
    lsu_op_e                     op_q;
    logic [2:0]                  last_q;
    logic [`LSU_ADDR_BITS-1:0]   addr_q;
    logic [`LSU_GROUP_WIDTH-1:0] data_q;

    logic [2:0] req_beats;
    logic       last_beat;
    logic       beat_hs;
    logic       can_accept;
    logic       req_hs;

    assign req_beats = beats_for_lmul(req.lmul);

    assign last_beat = (beat_cnt == last_q);
    assign beat_hs   = mem_req_valid && mem_req_ready;

    // a new request may enter on the cycle the last beat leaves
    assign can_accept = !busy || (beat_hs && last_beat);

    // loads also need the tag slot, stores do not
    assign req_ready = can_accept && (req.op == LSU_STORE || tag_ready);
    assign req_hs    = req_valid && req_ready;

    // tag handshake coincides with the load being accepted
    assign tag_valid  = req_valid && can_accept && (req.op == LSU_LOAD);
    assign tag.beats  = req_beats;

    assign mem_req_valid = busy;

    always_comb begin
        mem_req.write = (op_q == LSU_STORE);
        for (int j = 0; j < `LSU_BANKS; j++) begin
            mem_req.addr[j]  = addr_q + `LSU_ADDR_BITS'(j);
            mem_req.wdata[j] = data_q[j*`LSU_BANK_WIDTH +: `LSU_BANK_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busy     <= 1'b0;
            beat_cnt <= 3'd0;
            st_done  <= 1'b0;
        end else begin
            st_done <= beat_hs && last_beat && (op_q == LSU_STORE);
            if (req_hs) begin
                busy     <= 1'b1;
                beat_cnt <= 3'd0;
            end else if (beat_hs && last_beat) begin
                busy <= 1'b0;
            end else if (beat_hs) begin
                beat_cnt <= beat_cnt + 3'd1;
            end
        end
    end

    // next beat starts four words up, store data moves down one register
    always_ff @(posedge clk) begin
        if (req_hs) begin
            op_q   <= req.op;
            last_q <= req_beats - 3'd1;
            addr_q <= req.base;
            data_q <= req.data;
        end else if (beat_hs) begin
            addr_q <= addr_q + `LSU_ADDR_BITS'(`LSU_BANKS);
            data_q <= data_q >> `LSU_VLEN;
        end
    end

endmodule

`default_nettype wire

/* src/pipe_stage.sv */
// valid/ready stage register

`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     nrst,

    // upstream side
    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,

    // downstream side
    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);

    logic     full;
    payload_t data_q;

    // accept when empty or when the held entry drains this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

/* src/lsu_pkg.sv */
// vector lsu types

`default_nettype none

package lsu_pkg;

    `include "lsu_consts.svh"

    // unit-stride load or store
    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_e;

    // request from the vector register file side
    typedef struct packed {
        lsu_op_e                     op;
        logic [2:0]                  lmul;
        logic [`LSU_ADDR_BITS-1:0]   base;
        logic [`LSU_GROUP_WIDTH-1:0] data;
    } lsu_req_t;

    // one beat to the four banks
    typedef struct packed {
        logic                                          write;
        logic [`LSU_BANKS-1:0][`LSU_ADDR_BITS-1:0]     addr;
        logic [`LSU_BANKS-1:0][`LSU_BANK_WIDTH-1:0]    wdata;
    } bank_req_t;

    // number of beats a pending load will return
    typedef struct packed {
        logic [2:0] beats;
    } load_tag_t;

    typedef logic [`LSU_GROUP_WIDTH-1:0] load_result_t;

    // reserved lmul encodings fall back to a single register
    function automatic logic [2:0] beats_for_lmul(input logic [2:0] lmul);
        logic [2:0] beats;
        case (lmul)
            3'd1:    beats = 3'd2;
            3'd2:    beats = 3'd4;
            default: beats = 3'd1;
        endcase
        return beats;
    endfunction

endpackage

`default_nettype wire

/* src/lsu_consts.svh */
// vector lsu constants

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// one vector register
`define LSU_VLEN 128

// largest register group at lmul 2
`define LSU_MAX_REGS 4

// full group as seen by the register file
`define LSU_GROUP_WIDTH (`LSU_VLEN * `LSU_MAX_REGS)

// data memory organisation
`define LSU_BANKS 4
`define LSU_BANK_WIDTH 32

// word address into each bank
`define LSU_ADDR_BITS 12

`endif
